// File: source/gb_glue_pkg.sv
package gb_glue_pkg;

	//////////////////// Data widths

	typedef logic [15:0] host_word_t;
	typedef logic [7:0] dl_index_t;
	typedef logic [17:0] checksum_t;
	typedef logic signed [15:0] sample_t;
	typedef logic [23:0] colour_t;
	// First loaded colour sits in the top slot
	typedef colour_t [3:0] palette_t;
	typedef logic [31:0] lba_t;
	// Low LBA byte followed by the sector buffer address
	typedef logic [16:0] bk_addr_t;

	//////////////////// Host file indexes

	localparam dl_index_t idx_cart = 8'h01;
	localparam dl_index_t idx_cart_cgb = 8'h80;
	localparam dl_index_t idx_megaduck = 8'h81;
	localparam dl_index_t idx_palette = 8'h03;
	localparam dl_index_t idx_cgb_boot = 8'h04;
	localparam dl_index_t idx_dmg_boot = 8'h05;
	localparam dl_index_t idx_sgb_boot = 8'h06;

	// Boot ROM byte sums
	localparam checksum_t cs_mister_cgb0 = 18'h2CE10;
	localparam checksum_t cs_original_cgb = 18'h2F3EA;

	localparam palette_t palette_reset_value = 96'h828214517356305A5F1A3B49;

	// Last sector of a backup RAM transfer
	localparam lba_t sectors_full = 32'd511;
	localparam lba_t sectors_dupe = 32'd255;

	//////////////////// Grouped signals

	typedef struct packed {
		logic cart;
		logic megaduck;
		logic palette;
		logic cgb_boot;
		logic dmg_boot;
		logic sgb_boot;
	} dl_kind_t;

	typedef enum logic [1:0] {
		sel_gb1 = 2'd0,
		sel_gb2 = 2'd1,
		sel_mixed = 2'd2,
		sel_split = 2'd3
	} audio_sel_t;

	typedef enum logic {
		bk_idle = 1'b0,
		bk_busy = 1'b1
	} bk_state_t;

	typedef struct packed {
		logic autosave;
		logic dupe_save;
		logic rom_load_gb2;
		logic load_req;
		logic save_req;
	} menu_opts_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	typedef struct packed {
		lba_t lba;
		logic rd;
		logic wr;
	} sd_req_t;

endpackage

// File: source/download_decoder.sv
`timescale 1ns/10ps

module download_decoder (
	input logic clk_sys,
	input logic reset,
	input logic ioctl_download,
	input gb_glue_pkg::dl_index_t ioctl_index,
	output gb_glue_pkg::dl_kind_t kinds,
	output logic boot_start
);

	logic any_boot;
	logic any_boot_r;

	// Cart files match on the low six bits, the top two select the model
	assign kinds.cart = ioctl_download &&
		(ioctl_index[5:0] == gb_glue_pkg::idx_cart[5:0] ||
		ioctl_index == gb_glue_pkg::idx_cart_cgb);
	assign kinds.megaduck = ioctl_download && (ioctl_index == gb_glue_pkg::idx_megaduck);
	assign kinds.palette = ioctl_download && (ioctl_index == gb_glue_pkg::idx_palette);
	assign kinds.cgb_boot = ioctl_download && (ioctl_index == gb_glue_pkg::idx_cgb_boot);
	assign kinds.dmg_boot = ioctl_download && (ioctl_index == gb_glue_pkg::idx_dmg_boot);
	assign kinds.sgb_boot = ioctl_download && (ioctl_index == gb_glue_pkg::idx_sgb_boot);

	assign any_boot = kinds.cgb_boot | kinds.dmg_boot | kinds.sgb_boot;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			any_boot_r <= 1'b0;
		end else begin
			any_boot_r <= any_boot;
		end
	end

	// First cycle of a colour boot download
	assign boot_start = kinds.cgb_boot & ~any_boot_r;

endmodule

// File: source/palette_store.sv
`timescale 1ns/10ps

module palette_store (
	input logic clk_sys,
	input logic reset,
	input gb_glue_pkg::dl_kind_t kinds,
	input logic ioctl_wr,
	input gb_glue_pkg::host_word_t ioctl_dout,
	output gb_glue_pkg::palette_t palette
);

	logic [95:0] pal_bits;

	assign pal_bits = palette;

	// Each word moves the store up one byte pair, low byte first
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			palette <= gb_glue_pkg::palette_reset_value;
		end else if (kinds.palette && ioctl_wr) begin
			palette <= {pal_bits[79:0], ioctl_dout[7:0], ioctl_dout[15:8]};
		end
	end

endmodule

// File: source/boot_rom_tracker.sv
`timescale 1ns/10ps

module boot_rom_tracker (
	input logic clk_sys,
	input logic reset,
	input gb_glue_pkg::dl_kind_t kinds,
	input logic boot_start,
	input logic ioctl_wr,
	input gb_glue_pkg::host_word_t ioctl_dout,
	output logic custom_cgb,
	output logic custom_dmg,
	output logic real_cgb_boot,
	output logic gba_available,
	output logic fast_boot_available
);

	gb_glue_pkg::checksum_t checksum;
	logic mister_cgb;

	//////////////////// Custom boot flags

	// Sticky until reset once any word of that kind arrives
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			custom_cgb <= 1'b0;
			custom_dmg <= 1'b0;
		end else begin
			if (kinds.cgb_boot && ioctl_wr)
				custom_cgb <= 1'b1;
			if (kinds.dmg_boot && ioctl_wr)
				custom_dmg <= 1'b1;
		end
	end

	//////////////////// Colour boot ROM sum

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			checksum <= '0;
		end else if (boot_start) begin
			checksum <= '0;
		end else if (kinds.cgb_boot && ioctl_wr) begin
			checksum <= checksum + gb_glue_pkg::checksum_t'(ioctl_dout[15:8]) +
				gb_glue_pkg::checksum_t'(ioctl_dout[7:0]);
		end
	end

	assign mister_cgb = (checksum == gb_glue_pkg::cs_mister_cgb0);
	assign real_cgb_boot = (checksum == gb_glue_pkg::cs_original_cgb);

	// GBA mode needs a boot ROM known to support it
	assign gba_available = ~custom_cgb | real_cgb_boot | mister_cgb;

	// Foreign boot ROMs for both models rule out fast boot
	assign fast_boot_available = ~(custom_cgb & custom_dmg & ~mister_cgb);

endmodule

// File: source/audio_mixer.sv
`timescale 1ns/10ps

module audio_mixer (
	input logic clk_sys,
	input logic reset,
	input gb_glue_pkg::audio_sel_t audio_sel,
	input gb_glue_pkg::stereo_t core1_audio,
	input gb_glue_pkg::stereo_t core2_audio,
	output gb_glue_pkg::stereo_t audio_out
);

	gb_glue_pkg::sample_t c1_left_half;
	gb_glue_pkg::sample_t c1_right_half;
	gb_glue_pkg::sample_t c2_left_half;
	gb_glue_pkg::sample_t c2_right_half;

	// Halved samples keep the sums inside 16 bits
	assign c1_left_half = core1_audio.left >>> 1;
	assign c1_right_half = core1_audio.right >>> 1;
	assign c2_left_half = core2_audio.left >>> 1;
	assign c2_right_half = core2_audio.right >>> 1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_out <= '0;
		end else begin
			case (audio_sel)
				gb_glue_pkg::sel_gb1: audio_out <= core1_audio;
				gb_glue_pkg::sel_gb2: audio_out <= core2_audio;
				gb_glue_pkg::sel_mixed: begin
					audio_out.left <= c1_left_half + c2_left_half;
					audio_out.right <= c1_right_half + c2_right_half;
				end
				// Split puts core 1 in mono on the left, core 2 on the right
				gb_glue_pkg::sel_split: begin
					audio_out.left <= c1_left_half + c1_right_half;
					audio_out.right <= c2_left_half + c2_right_half;
				end
			endcase
		end
	end

endmodule

// File: source/backup_ram_ctrl.sv
`timescale 1ns/10ps

module backup_ram_ctrl (
	input logic clk_sys,
	input logic reset,
	input gb_glue_pkg::dl_kind_t kinds,
	input gb_glue_pkg::menu_opts_t opts,
	input logic ioctl_download,
	input logic osd_open,
	input logic img_mounted,
	input logic img_readonly,
	input logic img_size_nonzero,
	input logic core1_has_save,
	input logic core2_has_save,
	input logic cram1_wr,
	input logic cram2_wr,
	input logic sd_ack,
	input logic [7:0] sd_buff_addr,
	input logic sd_buff_wr,
	input gb_glue_pkg::host_word_t bk_q1,
	input gb_glue_pkg::host_word_t bk_q2,
	output gb_glue_pkg::sd_req_t sd_req,
	output gb_glue_pkg::host_word_t sd_buff_din,
	output gb_glue_pkg::bk_addr_t bk_addr,
	output logic bk_wr1,
	output logic bk_wr2,
	output logic led_user,
	output logic core_hold
);

	gb_glue_pkg::bk_state_t bk_state;
	gb_glue_pkg::lba_t lba;
	logic sd_rd;
	logic sd_wr;
	logic bk_loading;

	logic old_cart_dl;
	logic cart_dl_rise;
	logic cart_dl_fall;
	logic bk_ena;
	logic new_load;
	logic sav_pending;
	logic sav_supported;

	logic bk_load;
	logic bk_save;
	logic old_load;
	logic old_save;
	logic old_ack;
	logic last_sector;

	//////////////////// Save enable and pending

	assign cart_dl_rise = ~old_cart_dl & kinds.cart;
	assign cart_dl_fall = old_cart_dl & ~kinds.cart;
	assign sav_supported = (core1_has_save | core2_has_save) & bk_ena;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_cart_dl <= 1'b0;
			bk_ena <= 1'b0;
			new_load <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			old_cart_dl <= kinds.cart;

			// The save image gets mounted while the cart is still loading
			if (cart_dl_rise)
				bk_ena <= 1'b0;
			if (kinds.cart && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (cart_dl_fall && sav_supported)
				new_load <= 1'b1;
			else if (bk_state == gb_glue_pkg::bk_busy)
				new_load <= 1'b0;

			if ((cram1_wr | cram2_wr) && !osd_open && sav_supported)
				sav_pending <= 1'b1;
			else if (bk_state == gb_glue_pkg::bk_busy)
				sav_pending <= 1'b0;
		end
	end

	//////////////////// Sector requests

	assign bk_load = opts.load_req | new_load;
	assign bk_save = opts.save_req | (sav_pending & osd_open & opts.autosave);

	// Dupe mode moves only the first cartridge's half
	assign last_sector = (lba == gb_glue_pkg::sectors_full) ||
		(opts.dupe_save && lba == gb_glue_pkg::sectors_dupe);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack <= 1'b0;
			bk_state <= gb_glue_pkg::bk_idle;
			bk_loading <= 1'b0;
			lba <= '0;
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
		end else begin
			old_load <= bk_load;
			old_save <= bk_save;
			old_ack <= sd_ack;

			// Host took the request
			if (~old_ack & sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (bk_state)
				gb_glue_pkg::bk_idle: begin
					if (bk_ena && ((~old_load & bk_load) || (~old_save & bk_save))) begin
						bk_state <= gb_glue_pkg::bk_busy;
						bk_loading <= bk_load;
						lba <= '0;
						sd_rd <= bk_load;
						sd_wr <= ~bk_load;
					end
					// Fresh cart with a save image loads it right away
					if (cart_dl_fall && img_size_nonzero && bk_ena) begin
						bk_state <= gb_glue_pkg::bk_busy;
						bk_loading <= 1'b1;
						lba <= '0;
						sd_rd <= 1'b1;
						sd_wr <= 1'b0;
					end
				end
				gb_glue_pkg::bk_busy: begin
					if (old_ack & ~sd_ack) begin
						if (last_sector) begin
							bk_state <= gb_glue_pkg::bk_idle;
							bk_loading <= 1'b0;
						end else begin
							lba <= lba + 32'd1;
							sd_rd <= bk_loading;
							sd_wr <= ~bk_loading;
						end
					end
				end
			endcase
		end
	end

	assign sd_req.lba = lba;
	assign sd_req.rd = sd_rd;
	assign sd_req.wr = sd_wr;

	//////////////////// Buffer routing

	// LBA bit 8 picks the cartridge and dupe mode writes both
	assign bk_addr = {1'b0, lba[7:0], sd_buff_addr};
	assign bk_wr1 = ~lba[8] & ~(opts.rom_load_gb2 & opts.dupe_save) & sd_buff_wr & sd_ack;
	assign bk_wr2 = (lba[8] | opts.dupe_save) & sd_buff_wr & sd_ack;
	assign sd_buff_din = lba[8] ? bk_q2 : bk_q1;

	assign led_user = ioctl_download | sav_pending;
	assign core_hold = bk_loading;

endmodule

// File: source/gb_dual_glue.sv
`timescale 1ns/10ps

module gb_dual_glue (
	input logic clk_sys,
	input logic reset,

	// Host downloads and menu
	input logic ioctl_download,
	input gb_glue_pkg::dl_index_t ioctl_index,
	input logic ioctl_wr,
	input gb_glue_pkg::host_word_t ioctl_dout,
	input gb_glue_pkg::menu_opts_t opts,
	input gb_glue_pkg::audio_sel_t audio_sel,
	input logic osd_open,

	// Host save image and sector buffer
	input logic img_mounted,
	input logic img_readonly,
	input logic img_size_nonzero,
	input logic sd_ack,
	input logic [7:0] sd_buff_addr,
	input gb_glue_pkg::host_word_t sd_buff_dout,
	input logic sd_buff_wr,

	// Console side
	input gb_glue_pkg::stereo_t core1_audio,
	input gb_glue_pkg::stereo_t core2_audio,
	input logic core1_has_save,
	input logic core2_has_save,
	input logic cram1_wr,
	input logic cram2_wr,
	input gb_glue_pkg::host_word_t bk_q1,
	input gb_glue_pkg::host_word_t bk_q2,

	output gb_glue_pkg::palette_t palette,
	output logic custom_cgb,
	output logic custom_dmg,
	output logic real_cgb_boot,
	output logic gba_available,
	output logic fast_boot_available,
	output gb_glue_pkg::stereo_t audio_out,
	output gb_glue_pkg::sd_req_t sd_req,
	output gb_glue_pkg::host_word_t sd_buff_din,
	output gb_glue_pkg::bk_addr_t bk_addr,
	output gb_glue_pkg::host_word_t bk_data,
	output logic bk_wr1,
	output logic bk_wr2,
	output logic led_user,
	output logic core_hold
);

	gb_glue_pkg::dl_kind_t kinds;
	logic boot_start;

	// Sector data goes to both cartridges, the write strobes pick one
	assign bk_data = sd_buff_dout;

	download_decoder download_decoder_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index),
		.kinds(kinds),
		.boot_start(boot_start)
	);

	palette_store palette_store_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.kinds(kinds),
		.ioctl_wr(ioctl_wr),
		.ioctl_dout(ioctl_dout),
		.palette(palette)
	);

	boot_rom_tracker boot_rom_tracker_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.kinds(kinds),
		.boot_start(boot_start),
		.ioctl_wr(ioctl_wr),
		.ioctl_dout(ioctl_dout),
		.custom_cgb(custom_cgb),
		.custom_dmg(custom_dmg),
		.real_cgb_boot(real_cgb_boot),
		.gba_available(gba_available),
		.fast_boot_available(fast_boot_available)
	);

	audio_mixer audio_mixer_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.audio_sel(audio_sel),
		.core1_audio(core1_audio),
		.core2_audio(core2_audio),
		.audio_out(audio_out)
	);

	backup_ram_ctrl backup_ram_ctrl_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.kinds(kinds),
		.opts(opts),
		.ioctl_download(ioctl_download),
		.osd_open(osd_open),
		.img_mounted(img_mounted),
		.img_readonly(img_readonly),
		.img_size_nonzero(img_size_nonzero),
		.core1_has_save(core1_has_save),
		.core2_has_save(core2_has_save),
		.cram1_wr(cram1_wr),
		.cram2_wr(cram2_wr),
		.sd_ack(sd_ack),
		.sd_buff_addr(sd_buff_addr),
		.sd_buff_wr(sd_buff_wr),
		.bk_q1(bk_q1),
		.bk_q2(bk_q2),
		.sd_req(sd_req),
		.sd_buff_din(sd_buff_din),
		.bk_addr(bk_addr),
		.bk_wr1(bk_wr1),
		.bk_wr2(bk_wr2),
		.led_user(led_user),
		.core_hold(core_hold)
	);

endmodule

// File: dv/tb_checker.sv
`timescale 1ns/10ps

module tb_checker (
	input logic clk_sys,
	input logic reset,
	input logic ioctl_download,
	input gb_glue_pkg::dl_index_t ioctl_index,
	input logic ioctl_wr,
	input gb_glue_pkg::host_word_t ioctl_dout,
	input gb_glue_pkg::audio_sel_t audio_sel,
	input gb_glue_pkg::stereo_t core1_audio,
	input gb_glue_pkg::stereo_t core2_audio,
	input gb_glue_pkg::menu_opts_t opts,
	input logic sd_ack,
	input logic [7:0] sd_buff_addr,
	input gb_glue_pkg::host_word_t sd_buff_dout,
	input logic sd_buff_wr,
	input gb_glue_pkg::host_word_t bk_q1,
	input gb_glue_pkg::host_word_t bk_q2,
	input gb_glue_pkg::palette_t palette,
	input logic custom_cgb,
	input logic custom_dmg,
	input logic real_cgb_boot,
	input logic gba_available,
	input logic fast_boot_available,
	input gb_glue_pkg::stereo_t audio_out,
	input gb_glue_pkg::sd_req_t sd_req,
	input gb_glue_pkg::host_word_t sd_buff_din,
	input gb_glue_pkg::bk_addr_t bk_addr,
	input gb_glue_pkg::host_word_t bk_data,
	input logic bk_wr1,
	input logic bk_wr2,
	input logic led_user,
	input logic core_hold,
	input gb_glue_pkg::lba_t exp_last_lba,
	input logic exp_rd,
	input logic led_check,
	input logic exp_led,
	output int error_count
);

	logic [95:0] exp_pal;
	logic [17:0] sum;
	logic cust_cgb;
	logic cust_dmg;
	logic prev_boot;
	logic cgb_dl;
	logic exp_real;
	logic exp_gba;
	logic exp_fast;
	logic exp_wr1;
	logic exp_wr2;
	gb_glue_pkg::stereo_t exp_audio;
	gb_glue_pkg::lba_t cur_lba;
	logic active;
	logic is_rd;
	logic prev_ack;
	logic chk_next;
	logic last_done;

	initial error_count = 0;

	task automatic flag_error(input string msg);
		error_count++;
		$display("Mismatch at %0t: %s", $time, msg);
	endtask

	function automatic logic [15:0] half(input logic [15:0] s);
		return {s[15], s[15:1]};
	endfunction

	always @(posedge clk_sys) begin
		if (reset) begin
			exp_pal = gb_glue_pkg::palette_reset_value;
			sum = '0;
			cust_cgb = 1'b0;
			cust_dmg = 1'b0;
			prev_boot = 1'b0;
			exp_audio = '0;
			active = 1'b0;
			is_rd = 1'b0;
			cur_lba = '0;
			prev_ack = 1'b0;
			chk_next = 1'b0;
			last_done = 1'b0;
		end else begin
			//////////////////// Palette and boot ROM flags
			if (palette !== exp_pal)
				flag_error($sformatf("palette %h expected %h", palette, exp_pal));
			if ({custom_cgb, custom_dmg} !== {cust_cgb, cust_dmg})
				flag_error($sformatf("custom cgb/dmg %b%b expected %b%b",
					custom_cgb, custom_dmg, cust_cgb, cust_dmg));
			exp_real = (sum == gb_glue_pkg::cs_original_cgb);
			exp_gba = !cust_cgb || exp_real || sum == gb_glue_pkg::cs_mister_cgb0;
			exp_fast = !(cust_cgb && cust_dmg && sum != gb_glue_pkg::cs_mister_cgb0);
			if ({real_cgb_boot, gba_available, fast_boot_available} !==
				{exp_real, exp_gba, exp_fast})
				flag_error($sformatf("boot flags real/gba/fast %b%b%b expected %b%b%b sum %h",
					real_cgb_boot, gba_available, fast_boot_available,
					exp_real, exp_gba, exp_fast, sum));
			if (audio_out !== exp_audio)
				flag_error($sformatf("audio_out %h expected %h", audio_out, exp_audio));
			if (led_check && led_user !== exp_led)
				flag_error($sformatf("led_user %b expected %b", led_user, exp_led));

			if (ioctl_download && ioctl_index == 8'h03 && ioctl_wr)
				exp_pal = {exp_pal[79:0], ioctl_dout[7:0], ioctl_dout[15:8]};
			cgb_dl = ioctl_download && ioctl_index == 8'h04;
			// A colour boot download restarts the sum on its first cycle
			if (cgb_dl && !prev_boot)
				sum = '0;
			else if (cgb_dl && ioctl_wr)
				sum = sum + 18'(ioctl_dout[15:8]) + 18'(ioctl_dout[7:0]);
			if (cgb_dl && ioctl_wr)
				cust_cgb = 1'b1;
			if (ioctl_download && ioctl_index == 8'h05 && ioctl_wr)
				cust_dmg = 1'b1;
			prev_boot = ioctl_download && ioctl_index >= 8'h04 && ioctl_index <= 8'h06;

			case (audio_sel)
				gb_glue_pkg::sel_gb1: exp_audio = core1_audio;
				gb_glue_pkg::sel_gb2: exp_audio = core2_audio;
				gb_glue_pkg::sel_mixed: begin
					exp_audio.left = half(core1_audio.left) + half(core2_audio.left);
					exp_audio.right = half(core1_audio.right) + half(core2_audio.right);
				end
				default: begin
					exp_audio.left = half(core1_audio.left) + half(core1_audio.right);
					exp_audio.right = half(core2_audio.left) + half(core2_audio.right);
				end
			endcase

			//////////////////// Sector sequence
			if (chk_next) begin
				chk_next = 1'b0;
				if (last_done) begin
					active = 1'b0;
					if (sd_req.rd || sd_req.wr)
						flag_error("request raised after the last sector");
					if (core_hold)
						flag_error("core_hold still high after the transfer ended");
				end else begin
					cur_lba = cur_lba + 32'd1;
					if (sd_req.lba !== cur_lba || sd_req.rd !== is_rd || sd_req.wr !== ~is_rd)
						flag_error($sformatf(
							"next request lba %0d rd %b wr %b expected lba %0d",
							sd_req.lba, sd_req.rd, sd_req.wr, cur_lba));
				end
			end
			if (sd_ack && !prev_ack) begin
				if (!active) begin
					active = 1'b1;
					is_rd = exp_rd;
					cur_lba = '0;
				end
				if (sd_req.lba !== cur_lba || sd_req.rd !== is_rd || sd_req.wr !== ~is_rd)
					flag_error($sformatf(
						"acked request lba %0d rd %b wr %b expected lba %0d rd %b",
						sd_req.lba, sd_req.rd, sd_req.wr, cur_lba, is_rd));
				if (is_rd && !core_hold)
					flag_error("core_hold low during a load");
			end
			if (!sd_ack && prev_ack) begin
				chk_next = 1'b1;
				last_done = (cur_lba == exp_last_lba);
			end
			prev_ack = sd_ack;

			//////////////////// Buffer routing
			exp_wr1 = sd_buff_wr && sd_ack && !cur_lba[8] &&
				!(opts.rom_load_gb2 && opts.dupe_save);
			exp_wr2 = sd_buff_wr && sd_ack && (cur_lba[8] || opts.dupe_save);
			if ({bk_wr1, bk_wr2} !== {exp_wr1, exp_wr2})
				flag_error($sformatf("bk_wr1/bk_wr2 %b%b expected %b%b at lba %0d",
					bk_wr1, bk_wr2, exp_wr1, exp_wr2, cur_lba));
			if (bk_data !== sd_buff_dout)
				flag_error($sformatf("bk_data %h expected %h", bk_data, sd_buff_dout));
			if (sd_ack && sd_buff_din !== (cur_lba[8] ? bk_q2 : bk_q1))
				flag_error($sformatf("sd_buff_din %h wrong at lba %0d", sd_buff_din, cur_lba));
			if (sd_ack && bk_addr !== {1'b0, cur_lba[7:0], sd_buff_addr})
				flag_error($sformatf("bk_addr %h wrong at lba %0d", bk_addr, cur_lba));
		end
	end

endmodule

// File: dv/tb_gb_dual_glue.sv
`timescale 1ns/10ps

module tb_gb_dual_glue;

	typedef enum logic [2:0] {
		op_palette, op_boot, op_audio, op_cart, op_cram, op_save, op_led
	} op_t;

	typedef struct packed {
		op_t op;
		logic [7:0] index;
		logic [15:0] data;
		logic [15:0] data2;
		logic [15:0] count;
		gb_glue_pkg::menu_opts_t opts;
		logic [31:0] expect_val;
	} stim_rec_t;

	localparam int num_recs = 17;

	logic clk_sys;
	logic reset;
	logic ioctl_download;
	gb_glue_pkg::dl_index_t ioctl_index;
	logic ioctl_wr;
	gb_glue_pkg::host_word_t ioctl_dout;
	gb_glue_pkg::menu_opts_t opts;
	gb_glue_pkg::audio_sel_t audio_sel;
	logic osd_open;
	logic img_mounted;
	logic img_readonly;
	logic img_size_nonzero;
	logic sd_ack;
	logic [7:0] sd_buff_addr;
	gb_glue_pkg::host_word_t sd_buff_dout;
	logic sd_buff_wr;
	gb_glue_pkg::stereo_t core1_audio;
	gb_glue_pkg::stereo_t core2_audio;
	logic core1_has_save;
	logic core2_has_save;
	logic cram1_wr;
	logic cram2_wr;
	gb_glue_pkg::host_word_t bk_q1;
	gb_glue_pkg::host_word_t bk_q2;

	gb_glue_pkg::palette_t palette;
	logic custom_cgb;
	logic custom_dmg;
	logic real_cgb_boot;
	logic gba_available;
	logic fast_boot_available;
	gb_glue_pkg::stereo_t audio_out;
	gb_glue_pkg::sd_req_t sd_req;
	gb_glue_pkg::host_word_t sd_buff_din;
	gb_glue_pkg::bk_addr_t bk_addr;
	gb_glue_pkg::host_word_t bk_data;
	logic bk_wr1;
	logic bk_wr2;
	logic led_user;
	logic core_hold;

	gb_glue_pkg::lba_t exp_last_lba;
	logic exp_rd;
	logic led_check;
	logic exp_led;
	int value_errors;
	int timeout_count;
	logic [31:0] lfsr_state;
	stim_rec_t stim [0:num_recs-1];

	gb_dual_glue gb_dual_glue_inst (.*);

	tb_checker checker_inst (
		.clk_sys, .reset, .ioctl_download, .ioctl_index, .ioctl_wr, .ioctl_dout,
		.audio_sel, .core1_audio, .core2_audio, .opts, .sd_ack, .sd_buff_addr,
		.sd_buff_dout, .sd_buff_wr, .bk_q1, .bk_q2, .palette, .custom_cgb, .custom_dmg,
		.real_cgb_boot, .gba_available, .fast_boot_available, .audio_out, .sd_req,
		.sd_buff_din, .bk_addr, .bk_data, .bk_wr1, .bk_wr2, .led_user, .core_hold,
		.exp_last_lba, .exp_rd, .led_check, .exp_led,
		.error_count(value_errors)
	);

	always #20 clk_sys = ~clk_sys;

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[14:0], fb};
		end
		return r;
	endfunction

	task automatic start_download(input gb_glue_pkg::dl_index_t idx);
		@(negedge clk_sys);
		ioctl_download = 1'b1;
		ioctl_index = idx;
	endtask

	task automatic write_word(input gb_glue_pkg::host_word_t w);
		@(negedge clk_sys);
		ioctl_wr = 1'b1;
		ioctl_dout = w;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	task automatic end_download();
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		ioctl_index = '0;
	endtask

	task automatic wait_request(output logic ok);
		int n;
		n = 0;
		while (!(sd_req.rd || sd_req.wr) && n < 200) begin
			@(negedge clk_sys);
			n++;
		end
		ok = (n < 200);
		if (!ok) begin
			timeout_count++;
			$display("Timeout: the DUT raised no sector request at %0t", $time);
		end
	endtask

	task automatic wait_hold_low();
		int n;
		n = 0;
		while (core_hold && n < 100) begin
			@(negedge clk_sys);
			n++;
		end
		if (n >= 100) begin
			timeout_count++;
			$display("Timeout: core_hold stayed high after the load at %0t", $time);
		end
	endtask

	// Host side of the sector protocol with eight buffer words per sector
	task automatic serve_transfer(input logic [31:0] last);
		logic ok;
		logic [15:0] d;
		for (int s = 0; s <= int'(last); s++) begin
			wait_request(ok);
			if (!ok)
				return;
			d = rand_bits(2);
			repeat (int'(d[1:0]) + 1) @(negedge clk_sys);
			sd_ack = 1'b1;
			for (int a = 0; a < 8; a++) begin
				@(negedge clk_sys);
				sd_buff_addr = 8'(a);
				sd_buff_wr = 1'b1;
				sd_buff_dout = rand_bits(16);
				bk_q1 = rand_bits(16);
				bk_q2 = rand_bits(16);
				@(negedge clk_sys);
				sd_buff_wr = 1'b0;
			end
			@(negedge clk_sys);
			sd_ack = 1'b0;
		end
	endtask

	task automatic apply_record(input stim_rec_t rec);
		logic [15:0] w;
		w = rec.data;
		case (rec.op)
			op_palette, op_boot: begin
				start_download(rec.index);
				for (int i = 0; i < int'(rec.count); i++) begin
					write_word(w);
					if (rec.op == op_palette)
						w = w + 16'h1111;
				end
				if (rec.op == op_boot)
					write_word(rec.data2);
				end_download();
			end
			op_audio: begin
				@(negedge clk_sys);
				audio_sel = gb_glue_pkg::audio_sel_t'(rec.index[1:0]);
				for (int i = 0; i < int'(rec.count); i++) begin
					@(negedge clk_sys);
					core1_audio = {rand_bits(16), rand_bits(16)};
					core2_audio = {rand_bits(16), rand_bits(16)};
				end
			end
			op_cart: begin
				opts = rec.opts;
				exp_last_lba = rec.expect_val;
				exp_rd = 1'b1;
				start_download(rec.index);
				write_word(rand_bits(16));
				@(negedge clk_sys);
				img_mounted = 1'b1;
				@(negedge clk_sys);
				img_mounted = 1'b0;
				end_download();
				serve_transfer(rec.expect_val);
				wait_hold_low();
				repeat (3) @(negedge clk_sys);
			end
			op_cram: begin
				@(negedge clk_sys);
				osd_open = 1'b0;
				cram1_wr = 1'b1;
				@(negedge clk_sys);
				cram1_wr = 1'b0;
			end
			op_save: begin
				@(negedge clk_sys);
				opts = rec.opts;
				exp_last_lba = rec.expect_val;
				exp_rd = 1'b0;
				osd_open = 1'b1;
				serve_transfer(rec.expect_val);
				repeat (3) @(negedge clk_sys);
				osd_open = 1'b0;
			end
			default: begin
				@(negedge clk_sys);
				led_check = 1'b1;
				exp_led = rec.expect_val[0];
				@(negedge clk_sys);
				led_check = 1'b0;
			end
		endcase
	endtask

	initial begin
		// Boot words sum to the known checksums as 360 or 379 times 510 plus 224
		stim[0] = '{op_palette, 8'h03, 16'h1357, 16'h0000, 16'd8, 5'b00000, 32'd0};
		stim[1] = '{op_boot, 8'h04, 16'h1234, 16'h0056, 16'd10, 5'b00000, 32'd0};
		stim[2] = '{op_boot, 8'h05, 16'h00FF, 16'h0000, 16'd4, 5'b00000, 32'd0};
		stim[3] = '{op_boot, 8'h04, 16'hFFFF, 16'h00E0, 16'd360, 5'b00000, 32'd0};
		stim[4] = '{op_boot, 8'h04, 16'hFFFF, 16'h00E0, 16'd379, 5'b00000, 32'd0};
		stim[5] = '{op_boot, 8'h06, 16'hA5A5, 16'h0000, 16'd3, 5'b00000, 32'd0};
		stim[6] = '{op_audio, 8'h00, 16'h0000, 16'h0000, 16'd6, 5'b00000, 32'd0};
		stim[7] = '{op_audio, 8'h01, 16'h0000, 16'h0000, 16'd6, 5'b00000, 32'd0};
		stim[8] = '{op_audio, 8'h02, 16'h0000, 16'h0000, 16'd6, 5'b00000, 32'd0};
		stim[9] = '{op_audio, 8'h03, 16'h0000, 16'h0000, 16'd8, 5'b00000, 32'd0};
		stim[10] = '{op_cart, 8'h41, 16'h0000, 16'h0000, 16'd0, 5'b00000, 32'd511};
		stim[11] = '{op_cart, 8'h80, 16'h0000, 16'h0000, 16'd0, 5'b01000, 32'd255};
		stim[12] = '{op_cart, 8'h01, 16'h0000, 16'h0000, 16'd0, 5'b01100, 32'd255};
		stim[13] = '{op_cram, 8'h00, 16'h0000, 16'h0000, 16'd0, 5'b00000, 32'd0};
		stim[14] = '{op_led, 8'h00, 16'h0000, 16'h0000, 16'd0, 5'b00000, 32'd1};
		stim[15] = '{op_save, 8'h00, 16'h0000, 16'h0000, 16'd0, 5'b10000, 32'd511};
		stim[16] = '{op_led, 8'h00, 16'h0000, 16'h0000, 16'd0, 5'b10000, 32'd0};

		clk_sys = 1'b0;
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_wr = 1'b0;
		ioctl_dout = '0;
		opts = '0;
		audio_sel = gb_glue_pkg::sel_gb1;
		osd_open = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size_nonzero = 1'b1;
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
		core1_audio = '0;
		core2_audio = '0;
		core1_has_save = 1'b1;
		core2_has_save = 1'b0;
		cram1_wr = 1'b0;
		cram2_wr = 1'b0;
		bk_q1 = '0;
		bk_q2 = '0;
		exp_last_lba = '0;
		exp_rd = 1'b0;
		led_check = 1'b0;
		exp_led = 1'b0;
		timeout_count = 0;
		lfsr_state = 32'h28e9;

		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		for (int i = 0; i < num_recs; i++)
			apply_record(stim[i]);

		repeat (4) @(negedge clk_sys);
		$display("Error counts: %0d value, %0d timeout", value_errors, timeout_count);
		if (value_errors == 0 && timeout_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: gb_dual_glue.f
source/gb_glue_pkg.sv
source/download_decoder.sv
source/palette_store.sv
source/boot_rom_tracker.sv
source/audio_mixer.sv
source/backup_ram_ctrl.sv
source/gb_dual_glue.sv
dv/tb_checker.sv
dv/tb_gb_dual_glue.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench, pass only when the pass message shows up
verilator --binary --timing --top-module tb_gb_dual_glue -f gb_dual_glue.f -o sim_gb_dual_glue &&
sim_output=$(./obj_dir/sim_gb_dual_glue) &&
echo "$sim_output" &&
echo "$sim_output" | grep -q "Done: no errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
